/* hdl/ls_pkg.sv */
////////////////////////////////////////////////////////////
// shared encodings of the load/store subsystem
////////////////////////////////////////////////////////////

package ls_pkg;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD  = 5'b00000,  // LOAD  (0000011)
    OPC_STORE = 5'b01000,  // STORE (0100011)
    OPC_OTHER = 5'b11111   // anything else, decoder maps it here
  } ls_opc_t;

  // load func3, instruction bits 14:12
  // 3'b011 (LD) and 3'b110 (LWU) are RV64 only, 3'b111 reserved
  typedef enum logic [2:0] {
    LB  = 3'b000,  // byte, sign extended
    LH  = 3'b001,  // halfword, sign extended
    LW  = 3'b010,  // word
    LBU = 3'b100,  // byte, zero extended
    LHU = 3'b101   // halfword, zero extended
  } ls_load_t;

  // store func3, instruction bits 14:12
  // 3'b011 (SD) is RV64 only, the rest reserved
  typedef enum logic [2:0] {
    SB = 3'b000,  // byte
    SH = 3'b001,  // halfword
    SW = 3'b010   // word
  } ls_store_t;

endpackage

/* hdl/ls_decode.sv */
`timescale 1ns/1ns

module ls_decode (
  input  logic [31:0]       ins,    // instruction word
  input  logic [31:0]       rs1,    // base register value
  output ls_pkg::ls_opc_t   opc,    // major opcode
  output ls_pkg::ls_load_t  ld_f3,  // load type
  output ls_pkg::ls_store_t st_f3,  // store type
  output logic [31:0]       adr,    // effective address
  output logic              ill     // illegal instruction
);

  ////////////////////////////////////////////////////////////
  // field extraction
  ////////////////////////////////////////////////////////////

  logic [4:0]  opc_fld;  // bits 6:2
  logic [2:0]  f3;       // bits 14:12
  logic [31:0] imm;      // sign extended immediate
  logic        f3_ok;    // func3 is a legal RV32 encoding

  assign opc_fld = ins[6:2];
  assign f3      = ins[14:12];

  always_comb begin
    opc   = ls_pkg::OPC_OTHER;
    ld_f3 = ls_pkg::LW;   // defaults for non-memory ops
    st_f3 = ls_pkg::SW;
    imm   = 32'h0000_0000;
    f3_ok = 1'b0;
    case (opc_fld)
      ls_pkg::OPC_LOAD: begin
        opc = ls_pkg::OPC_LOAD;
        imm = {{20{ins[31]}}, ins[31:20]};  // I-type
        case (ls_pkg::ls_load_t'(f3))
          ls_pkg::LB, ls_pkg::LH, ls_pkg::LW, ls_pkg::LBU, ls_pkg::LHU: begin
            ld_f3 = ls_pkg::ls_load_t'(f3);
            f3_ok = 1'b1;
          end
          default: f3_ok = 1'b0;  // LD, LWU, reserved
        endcase
      end
      ls_pkg::OPC_STORE: begin
        opc = ls_pkg::OPC_STORE;
        imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};  // S-type, split field
        case (ls_pkg::ls_store_t'(f3))
          ls_pkg::SB, ls_pkg::SH, ls_pkg::SW: begin
            st_f3 = ls_pkg::ls_store_t'(f3);
            f3_ok = 1'b1;
          end
          default: f3_ok = 1'b0;  // SD, reserved
        endcase
      end
      default: begin
        opc = ls_pkg::OPC_OTHER;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // legality and address
  ////////////////////////////////////////////////////////////

  // compressed encodings and foreign opcodes are illegal here
  assign ill = (ins[1:0] != 2'b11) | ~f3_ok;

  assign adr = rs1 + imm;  // wraps modulo 2^32

endmodule

/* hdl/ls_unit.sv */
`timescale 1ns/1ns

module ls_unit #(
  parameter int ADR_W = 10  // byte address width of the ls bus
)(
  input  logic               clk,
  input  logic               rst,
  // from the decoder
  input  logic               run,     // instruction presented
  input  logic               ill,     // illegal instruction
  input  ls_pkg::ls_opc_t    opc,
  input  ls_pkg::ls_load_t   ld_f3,
  input  ls_pkg::ls_store_t  st_f3,
  input  logic [31:0]        adr,     // effective byte address
  input  logic [31:0]        wdt,     // store data, from rs2
  output logic [31:0]        rdt,     // aligned load result
  output logic               mal,     // misaligned access
  output logic               rdy,     // not stalled
  // ls bus
  output logic               ls_vld,  // request
  output logic               ls_wen,  // write
  output logic [ADR_W-1:0]   ls_adr,  // word aligned
  output logic [3:0]         ls_ben,  // byte enables
  output logic [31:0]        ls_wdt,  // write data
  input  logic [31:0]        ls_rdt,  // read data, one cycle late
  input  logic               ls_rdy   // accept
);

  logic                acc;      // legal load or store
  logic [1:0]          sz;       // 0 byte, 1 half, 2 word
  logic [3:0]          ben;      // lanes touched
  logic [31:0]         rep;      // store data replicated over lanes
  logic                ls_rtr;   // read transfer
  logic [1:0]          dly_off;  // byte offset of last read
  ls_pkg::ls_load_t    dly_f3;   // load type of last read
  logic [15:0]         dly_hlf;
  logic [7:0]          dly_byt;

  ////////////////////////////////////////////////////////////
  // access size and misalignment
  ////////////////////////////////////////////////////////////

  always_comb begin
    acc = 1'b0;
    sz  = 2'd2;
    if (!ill) begin
      case (opc)
        ls_pkg::OPC_LOAD: begin
          acc = 1'b1;
          case (ld_f3)
            ls_pkg::LB, ls_pkg::LBU: sz = 2'd0;
            ls_pkg::LH, ls_pkg::LHU: sz = 2'd1;
            default:                 sz = 2'd2;  // LW
          endcase
        end
        ls_pkg::OPC_STORE: begin
          acc = 1'b1;
          case (st_f3)
            ls_pkg::SB: sz = 2'd0;
            ls_pkg::SH: sz = 2'd1;
            default:    sz = 2'd2;  // SW
          endcase
        end
        default: acc = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (sz)
      2'd0:    mal = 1'b0;              // bytes never misalign
      2'd1:    mal = acc & adr[0];
      default: mal = acc & (|adr[1:0]);
    endcase
  end

  ////////////////////////////////////////////////////////////
  // bus request
  ////////////////////////////////////////////////////////////

  assign ls_vld = run & acc & ~mal;
  assign ls_wen = ls_vld & (opc == ls_pkg::OPC_STORE);
  assign ls_adr = ls_vld ? {adr[ADR_W-1:2], 2'b00} : '0;

  always_comb begin
    case (sz)
      2'd0:    ben = 4'b0001 << adr[1:0];
      2'd1:    ben = adr[1] ? 4'b1100 : 4'b0011;
      default: ben = 4'b1111;
    endcase
  end

  assign ls_ben = ls_vld ? ben : 4'b0000;

  // store lanes, every copy of the data lands on its own lane
  always_comb begin
    case (sz)
      2'd0:    rep = {4{wdt[7:0]}};
      2'd1:    rep = {2{wdt[15:0]}};
      default: rep = wdt;
    endcase
    for (int i = 0; i < 4; i++) begin
      ls_wdt[8*i +: 8] = (ls_wen && ben[i]) ? rep[8*i +: 8] : 8'h00;  // idle lanes zero
    end
  end

  ////////////////////////////////////////////////////////////
  // load alignment
  ////////////////////////////////////////////////////////////

  assign ls_rtr = ls_vld & ls_rdy & ~ls_wen;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dly_off <= 2'b00;
      dly_f3  <= ls_pkg::LW;
    end else if (ls_rtr) begin
      dly_off <= adr[1:0];
      dly_f3  <= ld_f3;
    end
  end

  assign dly_hlf = dly_off[1] ? ls_rdt[31:16] : ls_rdt[15:0];
  assign dly_byt = dly_off[0] ? dly_hlf[15:8] : dly_hlf[7:0];

  always_comb begin
    case (dly_f3)
      ls_pkg::LB:  rdt = {{24{dly_byt[7]}}, dly_byt};
      ls_pkg::LH:  rdt = {{16{dly_hlf[15]}}, dly_hlf};
      ls_pkg::LBU: rdt = {24'h00_0000, dly_byt};
      ls_pkg::LHU: rdt = {16'h0000, dly_hlf};
      default:     rdt = ls_rdt;  // LW
    endcase
  end

  assign rdy = ls_rdy;  // stall comes from the bus only

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // decoder flags must block the bus
  a_vld_legal: assert property (@(posedge clk) disable iff (rst)
    ls_vld |-> !mal && !ill);

  a_wr_ben: assert property (@(posedge clk) disable iff (rst)
    ls_vld && ls_wen |-> ls_ben != 4'b0000);

  // caller holds its inputs, so the request must not move while stalled
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    ls_vld && !ls_rdy |=> ls_vld && $stable({ls_wen, ls_adr, ls_ben, ls_wdt}));

endmodule

/* hdl/ls_data_mem.sv */
`timescale 1ns/1ns

module ls_data_mem #(
  parameter int ADR_W       = 10,  // byte address width
  parameter int WAIT_CYCLES = 2    // wait states before accept
)(
  input  logic             clk,
  input  logic             rst,
  input  logic             ls_vld,
  input  logic             ls_wen,
  input  logic [ADR_W-1:0] ls_adr,
  input  logic [3:0]       ls_ben,
  input  logic [31:0]      ls_wdt,
  output logic [31:0]      ls_rdt,
  output logic             ls_rdy
);

  localparam int WORDS = 2 ** (ADR_W - 2);
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  logic [31:0]      mem [WORDS];
  logic [CNT_W-1:0] cnt;   // cycles the current request has waited
  logic             trn;   // transfer this cycle

  ////////////////////////////////////////////////////////////
  // wait states
  ////////////////////////////////////////////////////////////

  assign ls_rdy = ~ls_vld | (cnt == CNT_W'(WAIT_CYCLES));
  assign trn    = ls_vld & ls_rdy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (trn) begin
      cnt <= '0;          // next request pays again
    end else if (ls_vld) begin
      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (trn && ls_wen) begin
      for (int i = 0; i < 4; i++) begin
        if (ls_ben[i]) begin
          mem[ls_adr[ADR_W-1:2]][8*i +: 8] <= ls_wdt[8*i +: 8];
        end
      end
    end
  end

  // whole word out and held until the next read
  always_ff @(posedge clk) begin
    if (trn && !ls_wen) begin
      ls_rdt <= mem[ls_adr[ADR_W-1:2]];
    end
  end

  a_rdy_idle: assert property (@(posedge clk) disable iff (rst)
    !ls_vld |-> ls_rdy);

endmodule

/* hdl/ls_subsys_top.sv */
`timescale 1ns/1ns

module ls_subsys_top #(
  parameter int ADR_W       = 10,  // 256 words
  parameter int WAIT_CYCLES = 2
)(
  input  logic        clk,
  input  logic        rst,
  input  logic        run,  // instruction valid
  input  logic [31:0] ins,
  input  logic [31:0] rs1,
  input  logic [31:0] rs2,
  output logic [31:0] rdt,  // load result, one cycle after rdy
  output logic        mal,
  output logic        ill,
  output logic        rdy
);

  // decoder to unit
  ls_pkg::ls_opc_t   opc;
  ls_pkg::ls_load_t  ld_f3;
  ls_pkg::ls_store_t st_f3;
  logic [31:0]       adr;

  // ls bus
  logic             ls_vld;
  logic             ls_wen;
  logic [ADR_W-1:0] ls_adr;
  logic [3:0]       ls_ben;
  logic [31:0]      ls_wdt;
  logic [31:0]      ls_rdt;
  logic             ls_rdy;

  ls_decode u_dec (
    .ins   (ins),
    .rs1   (rs1),
    .opc   (opc),
    .ld_f3 (ld_f3),
    .st_f3 (st_f3),
    .adr   (adr),
    .ill   (ill)
  );

  ls_unit #(
    .ADR_W (ADR_W)
  ) u_lsu (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .ill    (ill),
    .opc    (opc),
    .ld_f3  (ld_f3),
    .st_f3  (st_f3),
    .adr    (adr),
    .wdt    (rs2),     // store data straight from rs2
    .rdt    (rdt),
    .mal    (mal),
    .rdy    (rdy),
    .ls_vld (ls_vld),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_ben (ls_ben),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_rdy (ls_rdy)
  );

  ls_data_mem #(
    .ADR_W       (ADR_W),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_mem (
    .clk    (clk),
    .rst    (rst),
    .ls_vld (ls_vld),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_ben (ls_ben),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_rdy (ls_rdy)
  );

endmodule

/* tb/ls_subsys_tb.sv */
`timescale 1ns/1ns

module ls_subsys_tb;

  localparam int         WAIT_CYCLES = 2;
  localparam int         RDY_LIMIT   = WAIT_CYCLES + 8;  // cycles before rdy counts as lost
  localparam logic [6:0] OP_LD = {ls_pkg::OPC_LOAD, 2'b11};
  localparam logic [6:0] OP_ST = {ls_pkg::OPC_STORE, 2'b11};

  logic        clk = 1'b0;
  logic        rst;
  logic        run;
  logic [31:0] ins, rs1, rs2;
  logic [31:0] rdt;
  logic        mal, ill, rdy;

  logic [31:0] shadow [256];           // expected memory contents indexed by adr[9:2]
  logic [31:0] lfsr = 32'd82366;
  string       nm_q [$];               // pending checks drained by the compare process
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];
  time         t_q [$];
  int          n_checks = 0;
  int          n_errors = 0;
  int          chk0, err0;             // counts at test start

  always #2 clk = ~clk;  // 4 ns period

  ls_subsys_top #(
    .ADR_W       (10),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) DUT (
    .clk (clk), .rst (rst), .run (run), .ins (ins), .rs1 (rs1), .rs2 (rs2),
    .rdt (rdt), .mal (mal), .ill (ill), .rdy (rdy)
  );

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_ins(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [11:0] imm);
    if (op == OP_ST) return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], op};  // S-type
    return {imm, 5'd1, f3, 5'd2, op};                                   // I-type
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] w);
    return {w ^ 8'hc3, ~w, w, w + 8'h5a};  // every byte tied to the full index
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // rv32 loads use 000 001 010 100 101 and stores 000 001 010
  function automatic logic illegal_op(input logic [6:0] op, input logic [2:0] f3);
    if (op == OP_LD) return !(f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
    if (op == OP_ST) return f3 > 3'b010;
    return 1'b1;
  endfunction

  // misaligned when the address is not a multiple of the access size
  function automatic logic misaligned_access(input logic [31:0] a, input logic [2:0] f3);
    logic [1:0] mask;
    mask = 2'((1 << f3[1:0]) - 1);
    return (a[1:0] & mask) != 2'b00;
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] a, input logic [2:0] f3);
    logic [31:0] w;
    w = shadow[a[9:2]] >> (8 * a[1:0]);  // addressed byte to lane 0
    case (f3)
      ls_pkg::LB:  return {{24{w[7]}}, w[7:0]};
      ls_pkg::LH:  return {{16{w[15]}}, w[15:0]};
      ls_pkg::LBU: return {24'h00_0000, w[7:0]};
      ls_pkg::LHU: return {16'h0000, w[15:0]};
      default:     return w;
    endcase
  endfunction

  function automatic void store_to_shadow(input logic [31:0] a, input logic [2:0] f3,
                                          input logic [31:0] d);
    for (int i = 0; i < 4; i++) begin
      if (i >= a[1:0] && i < a[1:0] + (1 << f3[1:0]))
        shadow[a[9:2]][8*i +: 8] = d[8*(i - a[1:0]) +: 8];
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  function automatic void push_chk(input string nm, input logic [31:0] e, input logic [31:0] a);
    nm_q.push_back(nm);
    exp_q.push_back(e);
    act_q.push_back(a);
    t_q.push_back($time);
  endfunction

  // samples land at negedge and are compared on the next rising edge
  always @(posedge clk) begin : compare
    string       nm;
    logic [31:0] e, a;
    time         t;
    while (nm_q.size() > 0) begin
      nm = nm_q.pop_front();
      e  = exp_q.pop_front();
      a  = act_q.pop_front();
      t  = t_q.pop_front();
      n_checks++;
      if (a !== e) begin
        $display("MISMATCH time %0t signal %s expected %h actual %h", t, nm, e, a);
        n_errors++;
      end
    end
  end

  task automatic abort_run(input string why);
    $display("ERROR: %s at time %0t", why, $time);
    $display("Simulation failed");
    $finish;
  endtask

  // ends at the negedge of the cycle where rdy is high
  task automatic wait_rdy(output int stall);
    int n;
    n = 0;
    @(negedge clk);
    while (rdy !== 1'b1 && n < RDY_LIMIT) begin
      n++;
      @(negedge clk);
    end
    stall = n;
    if (rdy !== 1'b1) abort_run("rdy never rose for the presented instruction");
  endtask

  task automatic do_access(input logic [6:0] op, input logic [2:0] f3, input logic [11:0] imm,
                           input logic [31:0] base, input logic [31:0] data);
    logic [31:0] a, e_rdt;
    logic        e_ill, e_mal;
    int          stall;
    a     = base + {{20{imm[11]}}, imm};
    e_ill = illegal_op(op, f3);
    e_mal = !e_ill && misaligned_access(a, f3);
    e_rdt = load_value(a, f3);  // taken before any store of this access
    @(posedge clk);
    #1;
    run = 1'b1;
    ins = enc_ins(op, f3, imm);
    rs1 = base;
    rs2 = data;
    wait_rdy(stall);
    push_chk("ill", e_ill, ill);
    push_chk("mal", e_mal, mal);
    push_chk("stall", (e_ill || e_mal) ? 0 : WAIT_CYCLES, stall);  // flagged ops never wait
    if (!e_ill && !e_mal && op == OP_ST) store_to_shadow(a, f3, data);
    @(posedge clk);
    #1;
    run = 1'b0;
    if (!e_ill && !e_mal && op == OP_LD) begin
      @(negedge clk);
      push_chk("rdt", e_rdt, rdt);  // one cycle after the completing cycle
    end
  endtask

  task automatic start_test();
    chk0 = n_checks;
    err0 = n_errors;
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while (nm_q.size() != 0 && n < 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (nm_q.size() != 0) begin
      abort_run("checks were left unprocessed");
    end else begin
      $display("test %-12s %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [6:0] op;
    logic [2:0] f3;
    run = 1'b0;
    ins = '0;
    rs1 = '0;
    rs2 = '0;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;

    start_test();
    @(negedge clk);
    push_chk("rdy", 1, rdy);  // idle bus after reset
    for (int w = 0; w < 256; w++) do_access(OP_ST, ls_pkg::SW, 12'h000, w * 4, fill_word(8'(w)));
    end_test("fill");

    // words 20 to 22 with every lane and every load type
    start_test();
    for (int off = 0; off < 4; off++) begin
      do_access(OP_ST, ls_pkg::SB, 12'(off), 32'h50, rnd(32));
      do_access(OP_ST, ls_pkg::SH, 12'hff8 + 12'(off & 2), 32'h5c, rnd(32));  // negative imm
    end
    do_access(OP_ST, ls_pkg::SW, 12'h000, 32'h58, rnd(32));
    for (int w = 0; w < 3; w++)
      for (int off = 0; off < 4; off++)
        for (int k = 0; k < 8; k++)
          if (!illegal_op(OP_LD, 3'(k))) do_access(OP_LD, 3'(k), 12'(off), 32'h50 + 4 * w, 0);
    end_test("lanes");

    start_test();
    for (int off = 1; off < 4; off++) begin
      do_access(OP_ST, ls_pkg::SW, 12'(off), 32'h78, 32'hdead_beef);
      do_access(OP_LD, ls_pkg::LW, 12'(off), 32'h78, 0);
      if (off != 2) begin  // halfword only misaligned at odd offsets
        do_access(OP_ST, ls_pkg::SH, 12'(off), 32'h78, 32'h0000_abcd);
        do_access(OP_LD, ls_pkg::LH, 12'(off), 32'h78, 0);
        do_access(OP_LD, ls_pkg::LHU, 12'(off), 32'h78, 0);
      end
    end
    do_access(OP_LD, ls_pkg::LW, 12'h000, 32'h78, 0);  // word 30 untouched
    end_test("misaligned");

    start_test();
    do_access(7'b0010011, 3'b010, 12'h000, 32'h7c, 0);                 // OP-IMM
    do_access({ls_pkg::OPC_LOAD, 2'b10}, 3'b010, 12'h000, 32'h7c, 0);  // compressed quadrant
    do_access(OP_LD, 3'b110, 12'h000, 32'h7c, 0);                      // LWU
    do_access(OP_LD, 3'b011, 12'h000, 32'h7c, 0);                      // LD
    do_access(OP_LD, 3'b111, 12'h000, 32'h7c, 0);
    do_access(OP_ST, 3'b011, 12'h000, 32'h7c, 32'h1234_5678);          // SD
    do_access(OP_ST, 3'b101, 12'h000, 32'h7c, 32'h1234_5678);
    do_access(OP_LD, ls_pkg::LW, 12'h000, 32'h7c, 0);                  // word 31 untouched
    end_test("illegal");

    // stall count is checked per access on stores and loads back to back
    start_test();
    for (int i = 0; i < 4; i++) begin
      do_access(OP_ST, ls_pkg::SW, 12'(4 * i), 32'ha0, rnd(32));
      do_access(OP_LD, ls_pkg::LW, 12'(4 * i), 32'ha0, 0);
    end
    end_test("backpressure");

    start_test();
    for (int i = 0; i < 200; i++) begin
      op = rnd(1) ? OP_ST : OP_LD;
      f3 = 3'(rnd(3));
      if (illegal_op(op, f3)) f3 = 3'(f3[1:0] % 3);  // fold onto SB SH SW or LB LH LW
      do_access(op, f3, 12'(rnd(12)), rnd(32), rnd(32));
    end
    end_test("random");

    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  end

endmodule

/* ls_subsys.f */
hdl/ls_pkg.sv
hdl/ls_decode.sv
hdl/ls_unit.sv
hdl/ls_data_mem.sv
hdl/ls_subsys_top.sv
tb/ls_subsys_tb.sv

/* Bender.yml */
package:
  name: ls_subsys

sources:
  # design sources, compile order
  - target: any(rtl, test)
    files:
      - hdl/ls_pkg.sv
      - hdl/ls_decode.sv
      - hdl/ls_unit.sv
      - hdl/ls_data_mem.sv
      - hdl/ls_subsys_top.sv
  # testbench
  - target: test
    files:
      - tb/ls_subsys_tb.sv
